/* files.f */
+incdir+common
common/id_pkg.sv
hw/id_stage/reg_file.sv
hw/id_stage/instr_decoder.sv
hw/id_stage/imm_gen.sv
hw/id_stage/id_stage.sv
dv/id_stage_checker.sv
dv/id_stage_tb.sv

/* Makefile */
TOP = id_stage_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module id_stage
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/id_stage_tb.sv */
`include "id_defines.svh"
`default_nettype none

module id_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import id_pkg::*;

    localparam int MAX_CYCLES = 500;   // 4 reset + 32 preload + 400 random, with margin
    localparam int NUM_RANDOM = 400;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] instr;
    logic        reg_write;
    logic [4:0]  rd_select;
    logic [31:0] rd_data;
    logic [31:0] immd;
    logic [31:0] data1;
    logic [31:0] data2;
    alu_op_e     alu_op;
    logic [4:0]  destination;
    logic        write_reg;
    logic        mem_write;
    logic        mem_read;
    logic        src_immd;
    logic        branch;

    logic [31:0] model_regs [32];      // Reference copy of the register file
    logic [31:0] exp_immd;
    logic [31:0] exp_data1;
    logic [31:0] exp_data2;
    logic [3:0]  exp_alu;
    logic [4:0]  exp_dest;
    logic [4:0]  exp_ctrl;              // {write_reg, mem_write, mem_read, src_immd, branch}
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;
    int          total_errors;

    id_stage dut_i (.*);

    bind id_stage id_stage_checker checker_i (
        .clk(clk), .reset(reset), .write_reg(write_reg), .mem_write(mem_write),
        .mem_read(mem_read), .src_immd(src_immd), .branch(branch)
    );

    always #20 clk = ~clk;             // 40 ns period

    always @(posedge clk) begin        // Hang guard
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [31:0] reg_value(input logic [4:0] r, input logic wr,
                                              input logic [4:0] sel, input logic [31:0] data);
        if (r == 5'd0) return 32'h0;            // x0 reads zero
        if (wr && (sel == r)) return data;      // Same-cycle write-back
        return model_regs[r];
    endfunction

    function automatic logic is_decoded(input logic [6:0] opc);
        return (opc == `OPC_OP) || (opc == `OPC_OP_IMM) || (opc == `OPC_LOAD) ||
               (opc == `OPC_STORE) || (opc == `OPC_BRANCH) || (opc == `OPC_LUI);
    endfunction

    task automatic predict(input logic [31:0] ins, input logic wr, input logic [4:0] sel,
                           input logic [31:0] data);
        logic [2:0] f3;
        logic [4:0] r1;
        f3 = ins[14:12];
        r1 = ins[19:15];
        exp_alu  = ALU_ADD;                     // Bubble unless decoded
        exp_ctrl = 5'b00000;
        exp_immd = 32'h0;
        case (ins[6:0])
            `OPC_OP: begin
                exp_alu  = {ins[30], f3};
                exp_ctrl = 5'b10000;
            end
            `OPC_OP_IMM: begin
                exp_alu  = (f3 == 3'b101) ? {ins[30], f3} : {1'b0, f3};  // SRAI vs SRLI
                exp_ctrl = 5'b10010;
                exp_immd = {{20{ins[31]}}, ins[31:20]};
            end
            `OPC_LOAD: begin
                exp_ctrl = 5'b10110;
                exp_immd = {{20{ins[31]}}, ins[31:20]};
            end
            `OPC_STORE: begin
                exp_ctrl = 5'b01010;
                exp_immd = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            `OPC_BRANCH: begin
                exp_alu  = ALU_SUB;
                exp_ctrl = 5'b00001;
                exp_immd = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            `OPC_LUI: begin
                exp_ctrl = 5'b10010;
                exp_immd = {ins[31:12], 12'h000};
                r1       = 5'd0;                // Base is x0
            end
            default: ;
        endcase
        exp_data1 = reg_value(r1, wr, sel, data);
        exp_data2 = reg_value(ins[24:20], wr, sel, data);
        exp_dest  = ins[11:7];
    endtask

    ////////////////////
    // Stimulus and checks
    ////////////////////

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_outputs();
        compare_value("immd", immd, exp_immd);
        compare_value("data1", data1, exp_data1);
        compare_value("data2", data2, exp_data2);
        compare_value("alu_op", alu_op, exp_alu);
        compare_value("destination", destination, exp_dest);
        compare_value("write_reg", write_reg, exp_ctrl[4]);
        compare_value("mem_write", mem_write, exp_ctrl[3]);
        compare_value("mem_read", mem_read, exp_ctrl[2]);
        compare_value("src_immd", src_immd, exp_ctrl[1]);
        compare_value("branch", branch, exp_ctrl[0]);
    endtask

    // One instruction plus one write-back, checked after the capturing edge
    task automatic apply_cycle(input logic [31:0] ins, input logic wr, input logic [4:0] sel,
                               input logic [31:0] data);
        instr     = ins;
        reg_write = wr;
        rd_select = sel;
        rd_data   = data;
        predict(ins, wr, sel, data);
        if (wr && (sel != 5'd0)) model_regs[sel] = data;   // x0 write dropped
        @(posedge clk);
        #2;
        check_outputs();
    endtask

    function automatic logic [31:0] random_instr();
        logic [31:0] ins;
        logic [6:0]  opc;
        int          kind;
        ins  = $urandom;
        kind = $urandom_range(6, 0);
        case (kind)
            0: opc = `OPC_OP;
            1: opc = `OPC_OP_IMM;
            2: opc = `OPC_LOAD;
            3: opc = `OPC_STORE;
            4: opc = `OPC_BRANCH;
            5: opc = `OPC_LUI;
            default: begin                        // Non-decoded opcode
                opc = 7'($urandom);
                while (is_decoded(opc)) opc = 7'($urandom);
            end
        endcase
        ins[6:0] = opc;
        // Legal funct7 for R type and for shift immediates
        if ((opc == `OPC_OP) && (ins[14:12] != 3'b000) && (ins[14:12] != 3'b101))
            ins[31:25] = 7'h00;
        else if ((opc == `OPC_OP) || ((opc == `OPC_OP_IMM) && (ins[14:12] == 3'b101)))
            ins[31:25] = {1'b0, ins[30], 5'b00000};
        else if ((opc == `OPC_OP_IMM) && (ins[14:12] == 3'b001))
            ins[31:25] = 7'h00;
        return ins;
    endfunction

    initial begin
        logic [31:0] ins;
        logic [4:0]  sel;
        int          pick;
        void'($urandom(32'hcf71));
        reset     = 1'b1;
        instr     = 32'h0;
        reg_write = 1'b0;
        rd_select = 5'd0;
        rd_data   = 32'h0;
        repeat (4) @(posedge clk);
        #2;
        exp_immd  = 32'h0;                        // Bubble left by reset
        exp_data1 = 32'h0;
        exp_data2 = 32'h0;
        exp_alu   = ALU_ADD;
        exp_dest  = 5'd0;
        exp_ctrl  = 5'b00000;
        check_outputs();
        reset = 1'b0;

        for (int i = 0; i < 32; i++) begin        // Preload, x0 write must vanish
            apply_cycle(32'h0, 1'b1, 5'(i), $urandom);
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            ins  = random_instr();
            pick = $urandom_range(3, 0);
            if (pick == 0) sel = ins[19:15];      // Bypass onto rs1
            else if (pick == 1) sel = ins[24:20]; // Bypass onto rs2
            else sel = 5'($urandom);
            apply_cycle(ins, 1'($urandom), sel, $urandom);
        end

        total_errors = errors + dut_i.checker_i.fail_count;
        $display("Checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, dut_i.checker_i.fail_count);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/id_stage_checker.sv */
`include "id_defines.svh"
`default_nettype none

module id_stage_checker (
    input wire clk,
    input wire reset,
    input wire write_reg,
    input wire mem_write,
    input wire mem_read,
    input wire src_immd,
    input wire branch
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // Read by the testbench at the end of the run

    ////////////////////
    // Control invariants
    ////////////////////

    // A load and a store at once is never decoded
    a_mem_excl: assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write))
        else begin fail_count++; $error("mem_read and mem_write both high"); end

    // Branches write no register
    a_branch_no_wr: assert property (@(posedge clk) disable iff (reset) !(branch && write_reg))
        else begin fail_count++; $error("branch and write_reg both high"); end

    // Memory address is rs1 + immd
    a_store_imm: assert property (@(posedge clk) disable iff (reset) mem_write |-> src_immd)
        else begin fail_count++; $error("mem_write without src_immd"); end
    a_load_imm: assert property (@(posedge clk) disable iff (reset) mem_read |-> src_immd)
        else begin fail_count++; $error("mem_read without src_immd"); end

    // Reset edge leaves a bubble behind
    a_reset_bubble: assert property (@(posedge clk)
        reset |=> !(write_reg || mem_write || mem_read || src_immd || branch))
        else begin fail_count++; $error("control high in the cycle after reset"); end

endmodule

`default_nettype wire

/* hw/id_stage/id_stage.sv */
`include "id_defines.svh"
`default_nettype none

module id_stage (
    input  wire                    clk,
    input  wire                    reset,
    input  wire [`WORD_SIZE-1:0]   instr,        // From fetch, one per cycle
    input  wire                    reg_write,    // Write-back strobe
    input  wire [`REG_SEL-1:0]     rd_select,
    input  wire [`WORD_SIZE-1:0]   rd_data,
    output logic [`WORD_SIZE-1:0]  immd,
    output logic [`WORD_SIZE-1:0]  data1,
    output logic [`WORD_SIZE-1:0]  data2,
    output id_pkg::alu_op_e        alu_op,
    output logic [`REG_SEL-1:0]    destination,
    output logic                   write_reg,
    output logic                   mem_write,
    output logic                   mem_read,
    output logic                   src_immd,
    output logic                   branch
);
    import id_pkg::*;

    logic [`REG_SEL-1:0]   rs1_sel;      // Source register numbers
    logic [`REG_SEL-1:0]   rs2_sel;
    logic [`WORD_SIZE-1:0] rs1_data;     // Register file read data, bypassed
    logic [`WORD_SIZE-1:0] rs2_data;
    logic [`WORD_SIZE-1:0] imm_value;
    alu_op_e               dec_alu_op;
    logic                  dec_write_reg;
    logic                  dec_mem_write;
    logic                  dec_mem_read;
    logic                  dec_src_immd;
    logic                  dec_branch;

    instr_decoder u_decoder (
        .instr     (instr),
        .rs1_sel   (rs1_sel),
        .rs2_sel   (rs2_sel),
        .alu_op    (dec_alu_op),
        .write_reg (dec_write_reg),
        .mem_write (dec_mem_write),
        .mem_read  (dec_mem_read),
        .src_immd  (dec_src_immd),
        .branch    (dec_branch)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .immd  (imm_value)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .reg_write (reg_write),
        .rd_select (rd_select),
        .rd_data   (rd_data),
        .rs1_sel   (rs1_sel),
        .rs2_sel   (rs2_sel),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    ////////////////////
    // ID/EX register
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin          // Bubble, all controls low
            immd        <= '0;
            data1       <= '0;
            data2       <= '0;
            alu_op      <= ALU_ADD;
            destination <= '0;
            write_reg   <= 1'b0;
            mem_write   <= 1'b0;
            mem_read    <= 1'b0;
            src_immd    <= 1'b0;
            branch      <= 1'b0;
        end else begin
            immd        <= imm_value;
            data1       <= rs1_data;
            data2       <= rs2_data;
            alu_op      <= dec_alu_op;
            destination <= instr[11:7];   // rd field
            write_reg   <= dec_write_reg;
            mem_write   <= dec_mem_write;
            mem_read    <= dec_mem_read;
            src_immd    <= dec_src_immd;
            branch      <= dec_branch;
        end
    end

endmodule

`default_nettype wire

/* hw/id_stage/imm_gen.sv */
`include "id_defines.svh"
`default_nettype none

module imm_gen (
    input  wire [`WORD_SIZE-1:0]   instr,
    output logic [`WORD_SIZE-1:0]  immd
);
    import id_pkg::*;

    opcode_e opcode;
    logic    sign;            // Instruction bit 31

    assign opcode = opcode_e'(instr[6:0]);
    assign sign   = instr[31];

    ////////////////////
    // Format select
    ////////////////////

    always_comb begin
        case (opcode)
            OP_IMM, LOAD: begin   // I format
                immd = {{20{sign}}, instr[31:20]};
            end
            STORE: begin          // S format, split field
                immd = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            BRANCH: begin         // B format, halfword offset
                immd = {{19{sign}}, instr[31], instr[7], instr[30:25],
                        instr[11:8], 1'b0};
            end
            LUI: begin            // U format
                immd = {instr[31:12], 12'b0};
            end
            default: begin        // OP and unknown opcodes
                immd = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/id_stage/instr_decoder.sv */
`include "id_defines.svh"
`default_nettype none

module instr_decoder (
    input  wire [`WORD_SIZE-1:0]  instr,
    output logic [`REG_SEL-1:0]   rs1_sel,
    output logic [`REG_SEL-1:0]   rs2_sel,
    output id_pkg::alu_op_e       alu_op,
    output logic                  write_reg,
    output logic                  mem_write,
    output logic                  mem_read,
    output logic                  src_immd,   // Second ALU operand is immd
    output logic                  branch
);
    import id_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;    // SUB and SRA select

    assign opcode    = opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    ////////////////////
    // Register numbers
    ////////////////////

    // LUI adds the immediate to x0
    assign rs1_sel = (opcode == LUI) ? '0 : instr[19:15];
    assign rs2_sel = instr[24:20];

    ////////////////////
    // Control levels
    ////////////////////

    always_comb begin
        alu_op    = ALU_ADD;      // Default is a bubble
        write_reg = 1'b0;
        mem_write = 1'b0;
        mem_read  = 1'b0;
        src_immd  = 1'b0;
        branch    = 1'b0;
        case (opcode)
            OP: begin
                alu_op    = alu_op_e'({funct7_b5, funct3});
                write_reg = 1'b1;
            end
            OP_IMM: begin
                // Bit 30 only picks SRAI over SRLI, elsewhere it is immediate
                if (funct3 == 3'b101) begin
                    alu_op = alu_op_e'({funct7_b5, funct3});
                end else begin
                    alu_op = alu_op_e'({1'b0, funct3});
                end
                write_reg = 1'b1;
                src_immd  = 1'b1;
            end
            LOAD: begin           // Address is rs1 + immd
                write_reg = 1'b1;
                mem_read  = 1'b1;
                src_immd  = 1'b1;
            end
            STORE: begin
                mem_write = 1'b1;
                src_immd  = 1'b1;
            end
            BRANCH: begin
                alu_op = ALU_SUB; // Compare by subtraction
                branch = 1'b1;
            end
            LUI: begin            // x0 + U immediate
                write_reg = 1'b1;
                src_immd  = 1'b1;
            end
            default: ;            // Unknown opcode, keep bubble
        endcase
    end

endmodule

`default_nettype wire

/* hw/id_stage/reg_file.sv */
`include "id_defines.svh"
`default_nettype none

module reg_file (
    input  wire                    clk,
    input  wire                    reg_write,   // Write strobe from write-back
    input  wire [`REG_SEL-1:0]     rd_select,
    input  wire [`WORD_SIZE-1:0]   rd_data,
    input  wire [`REG_SEL-1:0]     rs1_sel,
    input  wire [`REG_SEL-1:0]     rs2_sel,
    output logic [`WORD_SIZE-1:0]  rs1_data,
    output logic [`WORD_SIZE-1:0]  rs2_data
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];   // x0 entry never written

    // x0 is dropped here, so a write to it never reaches the array
    always_ff @(posedge clk) begin
        if (reg_write && (rd_select != '0)) begin
            regs[rd_select] <= rd_data;
        end
    end

    ////////////////////
    // Read ports
    ////////////////////

    // Shared by both ports, bypass beats the stored word
    function automatic logic [`WORD_SIZE-1:0] read_port(input logic [`REG_SEL-1:0] sel);
        logic [`WORD_SIZE-1:0] value;
        if (sel == '0) begin
            value = '0;                           // Hard-wired zero
        end else if (reg_write && (sel == rd_select)) begin
            value = rd_data;                      // Write-through in same cycle
        end else begin
            value = regs[sel];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_sel);
        rs2_data = read_port(rs2_sel);
    end

endmodule

`default_nettype wire

/* common/id_pkg.sv */
`include "id_defines.svh"
`default_nettype none

package id_pkg;

    ////////////////////
    // Decoded opcodes
    ////////////////////

    // Anything not listed here decodes as a bubble
    typedef enum logic [6:0] {
        OP     = `OPC_OP,
        OP_IMM = `OPC_OP_IMM,
        LOAD   = `OPC_LOAD,
        STORE  = `OPC_STORE,
        BRANCH = `OPC_BRANCH,
        LUI    = `OPC_LUI
    } opcode_e;

    ////////////////////
    // ALU operation
    ////////////////////

    // Encoding is {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

endpackage

`default_nettype wire

/* common/id_defines.svh */
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

`default_nettype none

////////////////////
// RV32I sizes
////////////////////

`define WORD_SIZE 32            // Data and instruction width
`define NUM_REGS  32            // Architectural registers x0..x31
`define REG_SEL   5             // Register number width

////////////////////
// Opcode field, instr[6:0]
////////////////////

`define OPC_OP     7'b0110011   // R type arithmetic
`define OPC_OP_IMM 7'b0010011   // I type arithmetic
`define OPC_LOAD   7'b0000011   // Loads, I format
`define OPC_STORE  7'b0100011   // Stores, S format
`define OPC_BRANCH 7'b1100011   // Conditional branches, B format
`define OPC_LUI    7'b0110111   // Load upper immediate, U format

`default_nettype wire
`endif
